// File: Bender.yml
package:
  name: stm_index

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/stm_pkg.sv
      - stm/pipe_divider.sv
      - stm/stm_timer.sv
      - hw/idx_fifo.sv
      - hw/stm_reader.sv
      - hw/stm_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_stm_checker.sv
      - bench/tb_stm_top.sv

// File: bench/tb_stm_checker.sv
`include "stm_params.svh"

module tb_stm_checker (
  input logic                   CLK,
  input logic                   rst,
  input logic [`STM_TIME_W-1:0] sys_time,
  input logic                   update_in,
  input logic [`STM_IDX_W-1:0]  cycle [`STM_NUM_SEGMENT],
  input logic [`STM_IDX_W-1:0]  freq_div [`STM_NUM_SEGMENT],
  input logic                   focus_mode [`STM_NUM_SEGMENT],
  input logic                   active_segment,
  input stm_pkg::ram_wr_t       ram_wr,
  input logic                   drive_ready,
  input stm_pkg::drive_t        drive,
  input logic                   drive_valid,
  input logic                   update_out,
  input logic [`STM_IDX_W-1:0]  idx [`STM_NUM_SEGMENT]
);

  localparam int UPD_LAT = 1 + 2 * `STM_DIV_LAT + 2;
  // Edges between sampling sys_time and seeing its index at a clock edge
  localparam int IDX_DLY = 2 * `STM_DIV_LAT + 2;

  string test_name   = "startup";
  int    check_count = 0;
  int    error_count = 0;
  int    xfer_count  = 0;

  logic [31:0]           ram_model [`STM_NUM_SEGMENT * `STM_RAM_DEPTH];
  logic [`STM_IDX_W-1:0] cur_fd [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] cur_cy [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] prev_fd [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] prev_cy [`STM_NUM_SEGMENT];
  logic                  cur_ok = 1'b0;
  logic                  prev_ok = 1'b0;
  logic                  new_seen = 1'b0;
  // First tag computed fully with the newest settings
  logic [`STM_TAG_W-1:0] bound_tag = '0;
  logic                  loading = 1'b0;
  int                    load_cnt = 0;
  logic                  quiet = 1'b1;
  logic                  held = 1'b0;
  stm_pkg::drive_t       held_drive;
  logic                  have_last = 1'b0;
  stm_pkg::drive_t       last_xfer;
  logic                  seg_now = 1'b0;
  logic                  seg_settled = 1'b0;
  logic [`STM_TAG_W-1:0] tag_hist [$];

  function automatic logic [`STM_IDX_W-1:0] calc_idx(
    input logic [`STM_TAG_W-1:0] tag,
    input logic [`STM_IDX_W-1:0] fd,
    input logic [`STM_IDX_W-1:0] cy
  );
    logic [`STM_TAG_W-1:0] periods;
    logic [`STM_TAG_W-1:0] len;
    periods = tag / `STM_TAG_W'(fd);
    len     = `STM_TAG_W'(cy) + 1'b1;
    return `STM_IDX_W'(periods % len);
  endfunction

  task automatic check_value(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_failure(input string text);
    check_count++;
    error_count++;
    $display("Failure in %s: %s", test_name, text);
  endtask

  task automatic check_transfer();
    logic                  seg;
    logic [`STM_IDX_W-1:0] exp_cur;
    logic [`STM_IDX_W-1:0] exp_prev;
    logic [`STM_IDX_W-1:0] exp_idx;
    stm_pkg::stm_entry_u   exp_entry;
    logic [7:0]            exp_int;
    seg = drive.segment;
    xfer_count++;
    if (!cur_ok) begin
      report_failure("drive transfer happened before any settings were applied");
      return;
    end
    exp_cur  = calc_idx(drive.time_tag, cur_fd[seg], cur_cy[seg]);
    exp_prev = prev_ok ? calc_idx(drive.time_tag, prev_fd[seg], prev_cy[seg]) : exp_cur;
    // Tags equal to the boundary may come from either settings set
    if (drive.time_tag > bound_tag) begin
      new_seen = 1'b1;
      exp_idx  = exp_cur;
    end else if (drive.time_tag < bound_tag) begin
      exp_idx = exp_prev;
    end else if (!new_seen && prev_ok && drive.idx == exp_prev) begin
      exp_idx = exp_prev;
    end else begin
      exp_idx = exp_cur;
    end
    check_value("idx", 128'(exp_idx), 128'(drive.idx));

    exp_entry = ram_model[{seg, drive.idx[`STM_RAM_AW-1:0]}];
    exp_int   = focus_mode[seg] ? {exp_entry.focus.intensity, 4'b0000} : exp_entry.gain.intensity;
    check_value("entry", 128'(exp_entry), 128'(drive.entry));
    check_value("focus_mode", 128'(focus_mode[seg]), 128'(drive.focus_mode));
    check_value("intensity", 128'(exp_int), 128'(drive.intensity));

    if (have_last) begin
      if (drive.time_tag < last_xfer.time_tag) begin
        report_failure("time_tag went backwards between two drive transfers");
      end else if (drive.time_tag == last_xfer.time_tag && drive.segment == last_xfer.segment &&
                   drive.idx == last_xfer.idx && drive.time_tag != bound_tag) begin
        report_failure("the same request was delivered twice");
      end
    end
    if (seg == seg_now) begin
      seg_settled = 1'b1;
    end else if (seg_settled) begin
      report_failure("an old segment showed up after the switched segment had started");
    end
    have_last = 1'b1;
    last_xfer = drive;
  endtask

  always @(posedge CLK) begin
    if (rst) begin
      loading     = 1'b0;
      quiet       = 1'b1;
      cur_ok      = 1'b0;
      prev_ok     = 1'b0;
      held        = 1'b0;
      have_last   = 1'b0;
      seg_now     = active_segment;
      seg_settled = 1'b0;
    end else begin
      if (loading && load_cnt == UPD_LAT) begin
        check_value("update_out", 128'(1), 128'(update_out));
        loading = 1'b0;
        quiet   = 1'b0;
      end else begin
        if (loading) begin
          load_cnt++;
        end
        if (update_out) begin
          check_value("update_out", 128'(0), 128'(update_out));
        end
      end
      if (quiet && drive_valid) begin
        check_value("drive_valid", 128'(0), 128'(drive_valid));
      end
      // Back-pressure holds the drive word
      if (held) begin
        check_value("drive_valid while held", 128'(1), 128'(drive_valid));
        check_value("drive while held", 128'(held_drive), 128'(drive));
      end
      if (active_segment != seg_now) begin
        seg_now     = active_segment;
        seg_settled = 1'b0;
      end
      if (drive_valid && drive_ready) begin
        check_transfer();
      end
      held       = drive_valid && !drive_ready;
      held_drive = drive;
      // Index outputs while the settings are stable
      if (!quiet && !loading && tag_hist.size() == IDX_DLY) begin
        for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
          check_value("idx output", 128'(calc_idx(tag_hist[0], cur_fd[s], cur_cy[s])),
                      128'(idx[s]));
        end
      end
      if (!loading && update_in) begin
        for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
          prev_fd[s] = cur_fd[s];
          prev_cy[s] = cur_cy[s];
          cur_fd[s]  = freq_div[s];
          cur_cy[s]  = cycle[s];
        end
        prev_ok   = cur_ok;
        cur_ok    = 1'b1;
        new_seen  = 1'b0;
        bound_tag = sys_time[`STM_TIME_W-1 -: `STM_TAG_W];
        loading   = 1'b1;
        load_cnt  = 0;
      end
    end
    if (tag_hist.size() == IDX_DLY) begin
      void'(tag_hist.pop_front());
    end
    tag_hist.push_back(sys_time[`STM_TIME_W-1 -: `STM_TAG_W]);
    if (ram_wr.en) begin
      ram_model[{ram_wr.segment, ram_wr.addr}] = ram_wr.data;
    end
  end

endmodule

// File: bench/tb_stm_top.sv
`include "stm_params.svh"

module tb_stm_top;

  localparam int     NUM_TESTS    = 6;
  localparam int     PHASE_CYCLES = 1500;
  localparam int     UPD_WAIT     = 2 * (1 + 2 * `STM_DIV_LAT + 2);
  localparam longint TIME_LIMIT   =
    longint'(NUM_TESTS) * (PHASE_CYCLES + 2 * `STM_DIV_LAT + 50) * 100;

  logic                   CLK = 1'b0;
  logic                   rst;
  logic [`STM_TIME_W-1:0] sys_time;
  logic                   update_in;
  logic [`STM_IDX_W-1:0]  cycle [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0]  freq_div [`STM_NUM_SEGMENT];
  logic                   focus_mode [`STM_NUM_SEGMENT];
  logic                   active_segment;
  stm_pkg::ram_wr_t       ram_wr;
  logic                   drive_ready;
  stm_pkg::drive_t        drive;
  logic                   drive_valid;
  logic                   update_out;
  logic [`STM_IDX_W-1:0]  idx [`STM_NUM_SEGMENT];

  integer seed       = 32'h7bec;
  int     ready_mode = 0;
  int     fail_count = 0;
  int     tests_run  = 0;
  int     chk_mark;
  int     err_mark;
  int     xfer_mark;
  int     fail_mark;
  string  cur_test;

  always #50 CLK = ~CLK;

  stm_top UUT (
    .CLK           (CLK),
    .rst           (rst),
    .sys_time      (sys_time),
    .update_in     (update_in),
    .cycle         (cycle),
    .freq_div      (freq_div),
    .focus_mode    (focus_mode),
    .active_segment(active_segment),
    .ram_wr        (ram_wr),
    .drive_ready   (drive_ready),
    .drive         (drive),
    .drive_valid   (drive_valid),
    .update_out    (update_out),
    .idx           (idx)
  );

  tb_stm_checker u_chk (.*);

  // Ready modes 0 always, 1 random, 2 mostly stalled
  task automatic tick();
    @(negedge CLK);
    sys_time = sys_time + `STM_TIME_W'(1 + $unsigned($random(seed)) % 16);
    case (ready_mode)
      0: drive_ready = 1'b1;
      1: drive_ready = 1'($random(seed));
      default: drive_ready = ($unsigned($random(seed)) % 16) == 0;
    endcase
  endtask

  task automatic apply_reset();
    tick();
    rst       = 1'b1;
    update_in = 1'b0;
    ram_wr    = '0;
    repeat (3) tick();
    rst = 1'b0;
  endtask

  // Indices never exceed 255, so the low 256 words of each segment are enough
  task automatic fill_ram();
    for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
      for (int a = 0; a < 256; a++) begin
        tick();
        ram_wr.en      = 1'b1;
        ram_wr.segment = 1'(s);
        ram_wr.addr    = `STM_RAM_AW'(a);
        ram_wr.data    = 32'($random(seed));
      end
    end
    tick();
    ram_wr.en = 1'b0;
  endtask

  task automatic start_phase(input logic f0, input logic f1);
    apply_reset();
    focus_mode[0] = f0;
    focus_mode[1] = f1;
    fill_ram();
  endtask

  task automatic randomize_settings();
    for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
      freq_div[s] = `STM_IDX_W'(1 + $unsigned($random(seed)) % 64);
      cycle[s]    = `STM_IDX_W'($unsigned($random(seed)) % 256);
    end
  endtask

  // Optional second request lands in LOAD and must be ignored
  task automatic apply_settings(input bit second_pulse);
    tick();
    randomize_settings();
    update_in = 1'b1;
    tick();
    update_in = 1'b0;
    if (second_pulse) begin
      repeat (20) tick();
      randomize_settings();
      update_in = 1'b1;
      tick();
      update_in = 1'b0;
    end
  endtask

  task automatic wait_update();
    int n;
    n = 0;
    while (update_out !== 1'b1 && n < UPD_WAIT) begin
      tick();
      n++;
    end
    if (update_out !== 1'b1) begin
      fail_count++;
      $display("Failure in %s: no update_out pulse within %0d cycles", cur_test, UPD_WAIT);
    end
  endtask

  task automatic run_cycles(input int n, input bit toggle);
    for (int i = 0; i < n; i++) begin
      tick();
      if (toggle && i % 120 == 119) begin
        active_segment = ~active_segment;
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test          = name;
    u_chk.test_name   = name;
    chk_mark          = u_chk.check_count;
    err_mark          = u_chk.error_count;
    xfer_mark         = u_chk.xfer_count;
    fail_mark         = fail_count;
  endtask

  task automatic end_test();
    if (u_chk.xfer_count == xfer_mark) begin
      fail_count++;
      $display("Failure in %s: no drive transfers were seen", cur_test);
    end
    tests_run++;
    $display("Test %s: %0d checks, %0d errors", cur_test, u_chk.check_count - chk_mark,
             u_chk.error_count - err_mark + fail_count - fail_mark);
  endtask

  initial begin
    #(TIME_LIMIT);
    $display("Timeout: the run was stopped at %0t before all tests ended, no result", $time);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int total_err;
    rst            = 1'b1;
    update_in      = 1'b0;
    active_segment = 1'b0;
    ram_wr         = '0;
    drive_ready    = 1'b0;
    sys_time       = (`STM_TIME_W'(1) << 40) + `STM_TIME_W'($unsigned($random(seed)) % 4096);
    for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
      cycle[s]      = '0;
      freq_div[s]   = 16'd1;
      focus_mode[s] = 1'b0;
    end

    begin_test("basic");
    ready_mode = 1;
    start_phase(1'($random(seed)), 1'($random(seed)));
    apply_settings(1'b0);
    wait_update();
    run_cycles(600, 1'b0);
    end_test();

    begin_test("update_during_load");
    start_phase(1'b1, 1'b0);
    apply_settings(1'b0);
    wait_update();
    run_cycles(200, 1'b0);
    apply_settings(1'b1);
    wait_update();
    run_cycles(300, 1'b0);
    end_test();

    begin_test("back_pressure");
    ready_mode = 2;
    start_phase(1'($random(seed)), 1'($random(seed)));
    apply_settings(1'b0);
    wait_update();
    run_cycles(600, 1'b0);
    end_test();

    begin_test("segment_switch");
    ready_mode = 1;
    start_phase(1'b1, 1'b0);
    apply_settings(1'b0);
    wait_update();
    run_cycles(600, 1'b1);
    end_test();

    // Reset while the FIFO is full, then restart
    begin_test("mid_reset");
    ready_mode = 2;
    start_phase(1'b0, 1'b1);
    apply_settings(1'b0);
    wait_update();
    run_cycles(200, 1'b0);
    apply_reset();
    run_cycles(150, 1'b0);
    ready_mode = 1;
    apply_settings(1'b0);
    wait_update();
    run_cycles(200, 1'b0);
    end_test();

    begin_test("random_mix");
    start_phase(1'($random(seed)), 1'($random(seed)));
    apply_settings(1'b0);
    wait_update();
    run_cycles(300, 1'b0);
    apply_settings(1'b0);
    wait_update();
    run_cycles(300, 1'b1);
    end_test();

    total_err = u_chk.error_count + fail_count;
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, u_chk.check_count, total_err);
    if (total_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: common/stm_params.svh
`ifndef STM_PARAMS_SVH
`define STM_PARAMS_SVH

`define STM_NUM_SEGMENT 2
`define STM_TIME_W 57
// Divided time, system time bits 56:9
`define STM_TAG_W 48
`define STM_IDX_W 16

// One divider stage per dividend bit
`define STM_DIV_LAT 48

`define STM_FIFO_DEPTH 4

// Reduced from 2^16 entries per segment
`define STM_RAM_DEPTH 1024
`define STM_RAM_AW 10

`endif

// File: common/stm_pkg.sv
`include "stm_params.svh"

package stm_pkg;

  typedef struct packed {
    logic                  segment;
    logic [`STM_IDX_W-1:0] idx;
    logic [`STM_TAG_W-1:0] time_tag;
  } idx_req_t;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic [7:0] z;
    logic [3:0] intensity;
  } focus_t;

  typedef struct packed {
    logic [7:0]  phase;
    logic [7:0]  intensity;
    logic [15:0] reserved;
  } gain_t;

  // Same RAM word, meaning picked by the segment mode
  typedef union packed {
    focus_t focus;
    gain_t  gain;
  } stm_entry_u;

  typedef struct packed {
    logic                  segment;
    logic [`STM_IDX_W-1:0] idx;
    logic [`STM_TAG_W-1:0] time_tag;
    logic                  focus_mode;
    stm_entry_u            entry;
    logic [7:0]            intensity;
  } drive_t;

  typedef struct packed {
    logic                   en;
    logic                   segment;
    logic [`STM_RAM_AW-1:0] addr;
    logic [31:0]            data;
  } ram_wr_t;

endpackage

// File: flist.f
+incdir+common
common/stm_pkg.sv
stm/pipe_divider.sv
stm/stm_timer.sv
hw/idx_fifo.sv
hw/stm_reader.sv
hw/stm_top.sv
bench/tb_stm_checker.sv
bench/tb_stm_top.sv

// File: hw/idx_fifo.sv
`include "stm_params.svh"

module idx_fifo (
  input  logic              CLK,
  input  logic              rst,
  input  stm_pkg::idx_req_t in_req,
  input  logic              in_valid,
  output logic              in_ready,
  output stm_pkg::idx_req_t out_req,
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int DEPTH = `STM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  stm_pkg::idx_req_t mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              wr_en;
  logic              rd_en;

  assign in_ready  = count != CNT_W'(DEPTH);
  assign out_valid = count != '0;
  assign out_req   = mem[rd_ptr];
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_req;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A full buffer has wrapped pointers and takes no write
  a_no_write_full: assert property (
    @(posedge CLK) disable iff (rst)
    count == CNT_W'(DEPTH) |-> wr_ptr == rd_ptr && !wr_en
  );

endmodule

// File: hw/stm_reader.sv
`include "stm_params.svh"

module stm_reader (
  input  logic              CLK,
  input  logic              rst,
  input  stm_pkg::ram_wr_t  ram_wr,
  input  logic              focus_mode [`STM_NUM_SEGMENT],
  input  stm_pkg::idx_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output stm_pkg::drive_t   drive,
  output logic              drive_valid,
  input  logic              drive_ready
);

  localparam int RAM_AW = `STM_RAM_AW;
  localparam int SLOTS  = `STM_NUM_SEGMENT * `STM_RAM_DEPTH;

  // Both segments in one array, segment is the top address bit
  stm_pkg::stm_entry_u ram [SLOTS];
  stm_pkg::stm_entry_u rd_entry;
  stm_pkg::idx_req_t   rd_req;
  logic                rd_focus;
  logic                take;

  assign req_ready = !drive_valid || drive_ready;
  assign take      = req_valid && req_ready;

  always_ff @(posedge CLK) begin
    if (ram_wr.en) begin
      ram[{ram_wr.segment, ram_wr.addr}] <= ram_wr.data;
    end
  end

  // Output registers only load on a transfer, so they hold under back-pressure
  always_ff @(posedge CLK) begin
    if (take) begin
      rd_entry <= ram[{req.segment, req.idx[RAM_AW-1:0]}];
      rd_req   <= req;
      rd_focus <= focus_mode[req.segment];
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      drive_valid <= 1'b0;
    end else if (take) begin
      drive_valid <= 1'b1;
    end else if (drive_ready) begin
      drive_valid <= 1'b0;
    end
  end

  always_comb begin
    drive.segment    = rd_req.segment;
    drive.idx        = rd_req.idx;
    drive.time_tag   = rd_req.time_tag;
    drive.focus_mode = rd_focus;
    drive.entry      = rd_entry;
    if (rd_focus) begin
      drive.intensity = {rd_entry.focus.intensity, 4'b0000};
    end else begin
      drive.intensity = rd_entry.gain.intensity;
    end
  end

endmodule

// File: hw/stm_top.sv
`include "stm_params.svh"

module stm_top (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic [`STM_TIME_W-1:0] sys_time,
  input  logic                   update_in,
  input  logic [`STM_IDX_W-1:0]  cycle [`STM_NUM_SEGMENT],
  input  logic [`STM_IDX_W-1:0]  freq_div [`STM_NUM_SEGMENT],
  input  logic                   focus_mode [`STM_NUM_SEGMENT],
  input  logic                   active_segment,
  input  stm_pkg::ram_wr_t       ram_wr,
  input  logic                   drive_ready,
  output stm_pkg::drive_t        drive,
  output logic                   drive_valid,
  output logic                   update_out,
  output logic [`STM_IDX_W-1:0]  idx [`STM_NUM_SEGMENT]
);

  stm_pkg::idx_req_t req;
  logic              req_valid;
  logic              req_ready;
  stm_pkg::idx_req_t fifo_req;
  logic              fifo_valid;
  logic              fifo_ready;

  stm_timer u_timer (
    .CLK           (CLK),
    .rst           (rst),
    .sys_time      (sys_time),
    .update_in     (update_in),
    .cycle         (cycle),
    .freq_div      (freq_div),
    .active_segment(active_segment),
    .req_ready     (req_ready),
    .idx           (idx),
    .update_out    (update_out),
    .req           (req),
    .req_valid     (req_valid)
  );

  idx_fifo u_fifo (
    .CLK      (CLK),
    .rst      (rst),
    .in_req   (req),
    .in_valid (req_valid),
    .in_ready (req_ready),
    .out_req  (fifo_req),
    .out_valid(fifo_valid),
    .out_ready(fifo_ready)
  );

  stm_reader u_reader (
    .CLK        (CLK),
    .rst        (rst),
    .ram_wr     (ram_wr),
    .focus_mode (focus_mode),
    .req        (fifo_req),
    .req_valid  (fifo_valid),
    .req_ready  (fifo_ready),
    .drive      (drive),
    .drive_valid(drive_valid),
    .drive_ready(drive_ready)
  );

endmodule

// File: stm/pipe_divider.sv
module pipe_divider #(
  parameter int DIVIDEND_W = 48,
  parameter int DIVISOR_W  = 16
) (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic [DIVIDEND_W-1:0] dividend,
  input  logic [DIVISOR_W-1:0]  divisor,
  input  logic                  in_valid,
  output logic [DIVIDEND_W-1:0] quotient,
  output logic [DIVISOR_W-1:0]  remainder,
  output logic                  out_valid
);

  // Upper bits still to consume, quotient bits shift in from below
  logic [DIVIDEND_W-1:0] dq  [DIVIDEND_W+1];
  logic [DIVISOR_W-1:0]  rem [DIVIDEND_W+1];
  logic [DIVISOR_W-1:0]  dvs [DIVIDEND_W+1];
  logic                  vld [DIVIDEND_W+1];

  assign dq[0]  = dividend;
  assign rem[0] = '0;
  assign dvs[0] = divisor;
  assign vld[0] = in_valid;

  for (genvar s = 0; s < DIVIDEND_W; s++) begin : gen_stage
    logic [DIVISOR_W:0] trial;
    logic               fits;

    assign trial = {rem[s], dq[s][DIVIDEND_W-1]};
    assign fits  = trial >= {1'b0, dvs[s]};

    // Partial remainder stays below the divisor, so W bits suffice
    always_ff @(posedge CLK) begin
      dq[s+1]  <= {dq[s][DIVIDEND_W-2:0], fits};
      rem[s+1] <= fits ? trial[DIVISOR_W-1:0] - dvs[s] : trial[DIVISOR_W-1:0];
      dvs[s+1] <= dvs[s];
    end

    always_ff @(posedge CLK) begin
      if (rst) begin
        vld[s+1] <= 1'b0;
      end else begin
        vld[s+1] <= vld[s];
      end
    end
  end

  assign quotient  = dq[DIVIDEND_W];
  assign remainder = rem[DIVIDEND_W];
  assign out_valid = vld[DIVIDEND_W];

  a_divisor_nonzero: assert property (
    @(posedge CLK) disable iff (rst)
    in_valid |-> divisor != '0
  );

endmodule

// File: stm/stm_timer.sv
`include "stm_params.svh"

module stm_timer (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic [`STM_TIME_W-1:0] sys_time,
  input  logic                   update_in,
  input  logic [`STM_IDX_W-1:0]  cycle [`STM_NUM_SEGMENT],
  input  logic [`STM_IDX_W-1:0]  freq_div [`STM_NUM_SEGMENT],
  input  logic                   active_segment,
  input  logic                   req_ready,
  output logic [`STM_IDX_W-1:0]  idx [`STM_NUM_SEGMENT],
  output logic                   update_out,
  output stm_pkg::idx_req_t      req,
  output logic                   req_valid
);

  localparam int DIV_LAT    = `STM_DIV_LAT;
  localparam int TAG_STAGES = 2 * DIV_LAT + 2;
  localparam int UPD_LAT    = 1 + 2 * DIV_LAT + 2;
  localparam int CNT_W      = $clog2(UPD_LAT);

  typedef enum logic {
    IDLE,
    LOAD
  } state_t;

  state_t                state;
  logic [CNT_W-1:0]      cnt;
  logic                  accept;
  logic                  fire;
  logic                  configured;
  logic [`STM_TAG_W-1:0] tag_dly [TAG_STAGES];
  logic                  idx_vld [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] last_idx;
  logic                  last_seg;
  logic                  last_vld;
  logic                  idx_changed;
  logic                  raise;

  assign accept = (state == IDLE) && update_in;
  assign fire   = (state == LOAD) && (cnt == CNT_W'(UPD_LAT - 1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      state      <= IDLE;
      cnt        <= '0;
      update_out <= 1'b0;
      configured <= 1'b0;
    end else begin
      update_out <= fire;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (update_in) begin
            state      <= LOAD;
            configured <= 1'b1;
          end
        end
        LOAD: begin
          cnt <= cnt + 1'b1;
          if (fire) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Stage 0 is also the dividend register of both dividers
  always_ff @(posedge CLK) begin
    tag_dly[0] <= sys_time[`STM_TIME_W-1 -: `STM_TAG_W];
    for (int k = 1; k < TAG_STAGES; k++) begin
      tag_dly[k] <= tag_dly[k-1];
    end
  end

  for (genvar i = 0; i < `STM_NUM_SEGMENT; i++) begin : gen_seg
    logic [`STM_IDX_W-1:0] freq_div_q;
    logic [`STM_IDX_W:0]   cycle_q;
    logic [`STM_TAG_W-1:0] quo;
    logic                  quo_valid;
    logic [`STM_IDX_W:0]   rem;
    logic                  rem_valid;
    logic [`STM_IDX_W-1:0] idx_q;
    logic                  vld_q;

    always_ff @(posedge CLK) begin
      if (accept) begin
        freq_div_q <= freq_div[i];
        cycle_q    <= {1'b0, cycle[i]} + 1'b1;
      end
      if (rem_valid) begin
        idx_q <= rem[`STM_IDX_W-1:0];
      end
    end

    always_ff @(posedge CLK) begin
      if (rst) begin
        vld_q <= 1'b0;
      end else begin
        vld_q <= rem_valid;
      end
    end

    pipe_divider #(
      .DIVIDEND_W(`STM_TAG_W),
      .DIVISOR_W (`STM_IDX_W)
    ) u_div_freq (
      .CLK      (CLK),
      .rst      (rst),
      .dividend (tag_dly[0]),
      .divisor  (freq_div_q),
      .in_valid (configured),
      .quotient (quo),
      .remainder(),
      .out_valid(quo_valid)
    );

    // Remainder of the period count by the cycle length
    pipe_divider #(
      .DIVIDEND_W(`STM_TAG_W),
      .DIVISOR_W (`STM_IDX_W + 1)
    ) u_div_cycle (
      .CLK      (CLK),
      .rst      (rst),
      .dividend (quo),
      .divisor  (cycle_q),
      .in_valid (quo_valid),
      .quotient (),
      .remainder(rem),
      .out_valid(rem_valid)
    );

    assign idx[i]     = idx_q;
    assign idx_vld[i] = vld_q;
  end

  assign idx_changed = idx_vld[active_segment] &&
                       (!last_vld || idx[active_segment] != last_idx ||
                        active_segment != last_seg);

  // Results are mixed while LOAD runs, the pulse brings the first clean one
  assign raise = fire || (idx_changed && state == IDLE);

  always_ff @(posedge CLK) begin
    last_idx <= idx[active_segment];
    last_seg <= active_segment;
    if (raise) begin
      req.segment  <= active_segment;
      req.idx      <= idx[active_segment];
      req.time_tag <= tag_dly[TAG_STAGES-1];
    end
  end

  // Latest wins, a newer request replaces a pending one
  always_ff @(posedge CLK) begin
    if (rst) begin
      last_vld  <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      last_vld <= idx_vld[active_segment];
      if (raise) begin
        req_valid <= 1'b1;
      end else if (req_ready) begin
        req_valid <= 1'b0;
      end
    end
  end

  a_update_single: assert property (
    @(posedge CLK) disable iff (rst)
    update_out |=> !update_out
  );

  a_req_held: assert property (
    @(posedge CLK) disable iff (rst)
    req_valid && !req_ready |=> req_valid
  );

endmodule
